// ==== src.f ====
source/ddcPkg.sv
source/ddcRegs.sv
source/ddcLo.sv
source/ddcMixer.sv
source/cicDecimator.sv
source/variableGain.sv
source/halfbandDecimate.sv
source/ddcTop.sv
verification/ddcTop_asserts.sv
verification/ddcTb.sv

// ==== Makefile ====
TOOL      = verilator
LINTFLAGS = --lint-only -Wall
SIMFLAGS  = --binary --timing --assert -Wno-fatal
TOP       = ddcTb
FILELIST  = src.f
BUILDDIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP)

clean:
	rm -rf $(BUILDDIR)

// ==== verification/ddcTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcTb;
    import ddcPkg::*;

    localparam int maxRateLog2 = 4;

    logic clk;
    logic rstN;
    logic syncIn;
    logic offsetEn;
    logic [31:0] freqOffset;
    gainSetting gain;
    complexSample sampleIn;
    logic [11:0] addr;
    logic [31:0] din;
    logic [3:0] wrBytes;
    logic [31:0] dout;
    complexSample sampleOut;
    logic syncOut;
    logic [31:0] rngState;

    ddcTop #(
        .cicMaxRateLog2(maxRateLog2)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .syncIn(syncIn),
        .offsetEn(offsetEn),
        .freqOffset(freqOffset),
        .gain(gain),
        .sampleIn(sampleIn),
        .addr(addr),
        .din(din),
        .wr0(wrBytes[0]),
        .wr1(wrBytes[1]),
        .wr2(wrBytes[2]),
        .wr3(wrBytes[3]),
        .dout(dout),
        .sampleOut(sampleOut),
        .syncOut(syncOut)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // xorshift32.
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // small enough that a rotated sample never clips in the mixer.
    function automatic int dcLevel();
        return int'(nextRandom() % 32'd131071) - 65535;
    endfunction

    task automatic checkValue(input string name, input longint actual, input longint expected);
        if (actual != expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            $display("Finished with errors");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic resetDut();
        @(negedge clk);
        rstN = 1'b0;
        syncIn = 1'b0;
        offsetEn = 1'b0;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic writeReg(input logic [11:0] a, input logic [31:0] d, input logic [3:0] s);
        @(negedge clk);
        addr = a;
        din = d;
        wrBytes = s;
        @(negedge clk);
        wrBytes = 4'b0000;
    endtask

    task automatic readReg(input logic [11:0] a, output logic [31:0] d);
        @(negedge clk);
        addr = a;
        @(negedge clk);
        d = dout;
    endtask

    task automatic waitOutput();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) begin
                $display("timeout, no syncOut within %0d cycles", cycles);
                $display("Finished with errors");
                $fatal(1, "no output strobe");
            end
        end while (!syncOut);
    endtask

    // LO frequency ends up as loFreq.
    task automatic configureChain(input logic [31:0] center, input logic [31:0] loFreq,
                                  input int rate, input gainSetting g);
        resetDut();
        writeReg(centerFreqAddr, center, 4'hf);
        writeReg(cicRateAddr, 32'(rate), 4'h1);
        @(negedge clk);
        freqOffset = center + loFreq;
        offsetEn = 1'b1;
        gain = g;
        @(negedge clk);
        offsetEn = 1'b0;
    endtask

    task automatic driveDc(input int i, input int q);
        @(negedge clk);
        sampleIn.i = sampleWidth'(i);
        sampleIn.q = sampleWidth'(q);
        syncIn = 1'b1;
    endtask

    // skip the filter transients.
    task automatic checkSettled(input int expI, input int expQ);
        repeat (16) waitOutput();
        repeat (8) begin
            waitOutput();
            checkValue("sampleOut.i", sampleOut.i, expI);
            checkValue("sampleOut.q", sampleOut.q, expQ);
        end
    endtask

    task automatic registerAccess();
        logic [31:0] expCenter;
        logic [31:0] expRate;
        logic [31:0] data;
        logic [31:0] got;
        logic [3:0] strobes;
        expCenter = '0;
        expRate = '0;
        repeat (12) begin
            data = nextRandom();
            strobes = 4'(nextRandom());
            writeReg(centerFreqAddr, data, strobes);
            for (int b = 0; b < 4; b++) begin
                if (strobes[b]) begin
                    expCenter[8*b +: 8] = data[8*b +: 8];
                end
            end
            readReg(centerFreqAddr, got);
            checkValue("centerFreq", got, expCenter);
            data = nextRandom();
            strobes = 4'(nextRandom());
            if (nextRandom() % 2 == 0) begin
                data[7:0] = data[7:0] & 8'h07;
            end
            writeReg(cicRateAddr, data, strobes);
            // rate field is byte 0 only.
            if (strobes[0]) begin
                expRate = (data[7:0] > 8'(maxRateLog2)) ? 32'(maxRateLog2) : 32'(data[7:0]);
            end
            readReg(cicRateAddr, got);
            checkValue("cicRateLog2", got, expRate);
        end
        readReg(12'h100 | 12'(nextRandom()), got);
        checkValue("dout at unmapped address", got, 0);
    endtask

    task automatic dcPassthrough();
        int x;
        int y;
        x = dcLevel();
        y = dcLevel();
        configureChain(nextRandom(), 32'd0, 2, {4'd0, 16'd32768});
        driveDc(x, y);
        checkSettled(x, y);
    endtask

    task automatic decimationRatio();
        int window;
        int pulses;
        for (int k = 0; k <= maxRateLog2; k++) begin
            configureChain(nextRandom(), 32'd0, k, {4'd0, 16'd32768});
            driveDc(dcLevel(), dcLevel());
            window = 2 * (1 << k) * 20;
            repeat (3) waitOutput();
            pulses = 0;
            repeat (window) begin
                @(negedge clk);
                if (syncOut) begin
                    pulses++;
                end
            end
            checkValue("syncOut pulses per window",
                       (pulses >= 19 && pulses <= 21) ? 20 : pulses, 20);
        end
    endtask

    // quarter-rate LO, four phases cancel over one CIC window.
    task automatic imageRejection();
        configureChain(nextRandom(), 32'h4000_0000, 2, {4'd0, 16'd32768});
        driveDc(dcLevel(), dcLevel());
        checkSettled(0, 0);
    endtask

    task automatic gainSaturation();
        int x;
        int y;
        int big;
        x = dcLevel();
        y = dcLevel();
        configureChain(nextRandom(), 32'd0, 2, {4'd1, 16'd16384});
        driveDc(x, y);
        checkSettled(x, y);
        big = 20000 + int'(nextRandom() % 32'd100000);
        configureChain(nextRandom(), 32'd0, 2, {4'd3, 16'd32768});
        driveDc(big, -big);
        checkSettled(131071, -131072);
    endtask

    initial begin
        rngState = 32'd6365;
        rstN = 1'b0;
        syncIn = 1'b0;
        offsetEn = 1'b0;
        freqOffset = '0;
        gain = '0;
        sampleIn = '0;
        addr = '0;
        din = '0;
        wrBytes = 4'b0000;
        resetDut();
        registerAccess();
        dcPassthrough();
        decimationRatio();
        imageRejection();
        gainSaturation();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/ddcTop_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcTop_asserts (
    input logic clk,
    input logic rstN,
    input logic syncIn,
    input logic loStrobe,
    input logic mixStrobe,
    input logic cicStrobe,
    input logic gainStrobe,
    input logic syncOut
);
    logic syncSeen;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            syncSeen <= 1'b0;
        end else if (syncIn) begin
            syncSeen <= 1'b1;
        end
    end

    singlePulse: assert property (@(posedge clk) disable iff (!rstN) syncOut |=> !syncOut)
        else $error("syncOut high on two consecutive cycles");

    strobesInReset: assert property (@(posedge clk)
        !rstN |=> !(loStrobe || mixStrobe || cicStrobe || gainStrobe || syncOut))
        else $error("strobe high while in reset");

    // an input sample has to be seen two or more cycles earlier.
    outputAfterInput: assert property (@(posedge clk) disable iff (!rstN)
        syncOut |-> $past(syncSeen))
        else $error("syncOut with no earlier syncIn");

endmodule

bind ddcTop ddcTop_asserts asserts (
    .clk(clk),
    .rstN(rstN),
    .syncIn(syncIn),
    .loStrobe(loStrobe),
    .mixStrobe(mixStrobe),
    .cicStrobe(cicStrobe),
    .gainStrobe(gainStrobe),
    .syncOut(syncOut)
);

`default_nettype wire

// ==== source/ddcTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcTop #(
    parameter int cicMaxRateLog2 = 4
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 syncIn,
    input  logic                 offsetEn,
    input  logic [31:0]          freqOffset,
    input  ddcPkg::gainSetting   gain,
    input  ddcPkg::complexSample sampleIn,
    input  logic [11:0]          addr,
    input  logic [31:0]          din,
    input  logic                 wr0,
    input  logic                 wr1,
    input  logic                 wr2,
    input  logic                 wr3,
    output logic [31:0]          dout,
    output ddcPkg::complexSample sampleOut,
    output logic                 syncOut
);
    import ddcPkg::*;

    localparam int rateWidth = $clog2(cicMaxRateLog2 + 1);

    logic [31:0] centerFreq;
    logic [rateWidth-1:0] cicRateLog2;
    complexSample mixIn;
    complexSample loOut;
    complexSample mixOut;
    complexSample cicOut;
    complexSample gainOut;
    logic loStrobe;
    logic mixStrobe;
    logic cicStrobe;
    logic gainStrobe;

    // input sample lines up with the registered LO output.
    always_ff @(posedge clk) begin
        if (syncIn) begin
            mixIn <= sampleIn;
        end
    end

    ddcRegs #(
        .cicMaxRateLog2(cicMaxRateLog2)
    ) regs (
        .clk(clk),
        .rstN(rstN),
        .addr(addr),
        .din(din),
        .wr0(wr0),
        .wr1(wr1),
        .wr2(wr2),
        .wr3(wr3),
        .dout(dout),
        .centerFreq(centerFreq),
        .cicRateLog2(cicRateLog2)
    );

    ddcLo lo (
        .clk(clk),
        .rstN(rstN),
        .syncIn(syncIn),
        .offsetEn(offsetEn),
        .freqOffset(freqOffset),
        .centerFreq(centerFreq),
        .loOut(loOut),
        .loStrobe(loStrobe)
    );

    ddcMixer mixer (
        .clk(clk),
        .rstN(rstN),
        .sampleIn(mixIn),
        .loIn(loOut),
        .strobeIn(loStrobe),
        .mixOut(mixOut),
        .strobeOut(mixStrobe)
    );

    cicDecimator #(
        .cicMaxRateLog2(cicMaxRateLog2)
    ) cic (
        .clk(clk),
        .rstN(rstN),
        .rateLog2(cicRateLog2),
        .sampleIn(mixOut),
        .strobeIn(mixStrobe),
        .sampleOut(cicOut),
        .strobeOut(cicStrobe)
    );

    variableGain agc (
        .clk(clk),
        .rstN(rstN),
        .gain(gain),
        .sampleIn(cicOut),
        .strobeIn(cicStrobe),
        .sampleOut(gainOut),
        .strobeOut(gainStrobe)
    );

    halfbandDecimate hb (
        .clk(clk),
        .rstN(rstN),
        .sampleIn(gainOut),
        .strobeIn(gainStrobe),
        .sampleOut(sampleOut),
        .strobeOut(syncOut)
    );

endmodule

`default_nettype wire

// ==== source/halfbandDecimate.sv ====
`timescale 1ns/1ps
`default_nettype none

module halfbandDecimate (
    input  logic                 clk,
    input  logic                 rstN,
    input  ddcPkg::complexSample sampleIn,
    input  logic                 strobeIn,
    output ddcPkg::complexSample sampleOut,
    output logic                 strobeOut
);
    import ddcPkg::*;

    logic signed [sampleWidth-1:0] dly [2][6];
    logic signed [sampleWidth-1:0] tap [2][7];
    logic signed [sampleWidth+7:0] acc [2];
    logic phase;

    always_comb begin
        tap[0][0] = sampleIn.i;
        tap[1][0] = sampleIn.q;
        for (int r = 0; r < 2; r++) begin
            for (int k = 1; k < 7; k++) begin
                tap[r][k] = dly[r][k-1];
            end
            // coefficients -2 0 18 32 18 0 -2, zero taps left out.
            acc[r] = 32 * tap[r][3] + 18 * (tap[r][2] + tap[r][4])
                   - 2 * (tap[r][0] + tap[r][6]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < 2; r++) begin
                for (int k = 0; k < 6; k++) begin
                    dly[r][k] <= '0;
                end
            end
            phase <= 1'b0;
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= strobeIn && phase;
            if (strobeIn) begin
                phase <= ~phase;
                for (int r = 0; r < 2; r++) begin
                    for (int k = 0; k < 6; k++) begin
                        dly[r][k] <= tap[r][k];
                    end
                end
            end
        end
    end

    // taps sum to 64.
    always_ff @(posedge clk) begin
        if (strobeIn && phase) begin
            sampleOut.i <= saturate(acc[0] >>> 6);
            sampleOut.q <= saturate(acc[1] >>> 6);
        end
    end

endmodule

`default_nettype wire

// ==== source/variableGain.sv ====
`timescale 1ns/1ps
`default_nettype none

module variableGain (
    input  logic                 clk,
    input  logic                 rstN,
    input  ddcPkg::gainSetting   gain,
    input  ddcPkg::complexSample sampleIn,
    input  logic                 strobeIn,
    output ddcPkg::complexSample sampleOut,
    output logic                 strobeOut
);
    import ddcPkg::*;

    logic signed [16:0] mantSigned;
    logic signed [63:0] wide [2];

    assign mantSigned = $signed({1'b0, gain.mantissa});

    // mantissa is Q1.15; exponent shift goes first so no LSB is lost.
    always_comb begin
        wide[0] = ((sampleIn.i * mantSigned) <<< gain.exponent) >>> 15;
        wide[1] = ((sampleIn.q * mantSigned) <<< gain.exponent) >>> 15;
    end

    always_ff @(posedge clk) begin
        if (strobeIn) begin
            sampleOut.i <= saturate(wide[0]);
            sampleOut.q <= saturate(wide[1]);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= strobeIn;
        end
    end

endmodule

`default_nettype wire

// ==== source/cicDecimator.sv ====
`timescale 1ns/1ps
`default_nettype none

module cicDecimator #(
    parameter int cicMaxRateLog2 = 4
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [$clog2(cicMaxRateLog2 + 1)-1:0] rateLog2,
    input  ddcPkg::complexSample                  sampleIn,
    input  logic                                  strobeIn,
    output ddcPkg::complexSample                  sampleOut,
    output logic                                  strobeOut
);
    import ddcPkg::*;

    // two stages grow by rate squared.
    localparam int accWidth = sampleWidth + 2 * cicMaxRateLog2;

    logic signed [accWidth-1:0] railIn [2];
    logic signed [accWidth-1:0] int1 [2];
    logic signed [accWidth-1:0] int2 [2];
    logic signed [accWidth-1:0] int1Next [2];
    logic signed [accWidth-1:0] int2Next [2];
    logic signed [accWidth-1:0] comb1Dly [2];
    logic signed [accWidth-1:0] comb2Dly [2];
    logic signed [accWidth-1:0] comb1 [2];
    logic signed [accWidth-1:0] comb2 [2];
    logic signed [accWidth-1:0] scaled [2];
    logic [cicMaxRateLog2-1:0] decCount;
    logic lastStrobe;

    assign lastStrobe = (decCount >= cicMaxRateLog2'((1 << rateLog2) - 1));

    always_comb begin
        railIn[0] = accWidth'(sampleIn.i);
        railIn[1] = accWidth'(sampleIn.q);
        for (int r = 0; r < 2; r++) begin
            int1Next[r] = int1[r] + railIn[r];
            int2Next[r] = int2[r] + int1[r];
            comb1[r] = int2Next[r] - comb1Dly[r];
            comb2[r] = comb1[r] - comb2Dly[r];
            // divide by rate squared for unity DC gain.
            scaled[r] = comb2[r] >>> (2 * rateLog2);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < 2; r++) begin
                int1[r] <= '0;
                int2[r] <= '0;
                comb1Dly[r] <= '0;
                comb2Dly[r] <= '0;
            end
            decCount <= '0;
            strobeOut <= 1'b0;
        end else begin
            strobeOut <= strobeIn && lastStrobe;
            if (strobeIn) begin
                decCount <= lastStrobe ? '0 : decCount + 1'b1;
                for (int r = 0; r < 2; r++) begin
                    int1[r] <= int1Next[r];
                    int2[r] <= int2Next[r];
                    if (lastStrobe) begin
                        comb1Dly[r] <= int2Next[r];
                        comb2Dly[r] <= comb1[r];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (strobeIn && lastStrobe) begin
            sampleOut.i <= scaled[0][sampleWidth-1:0];
            sampleOut.q <= scaled[1][sampleWidth-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== source/ddcMixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcMixer (
    input  logic                 clk,
    input  logic                 rstN,
    input  ddcPkg::complexSample sampleIn,
    input  ddcPkg::complexSample loIn,
    input  logic                 strobeIn,
    output ddcPkg::complexSample mixOut,
    output logic                 strobeOut
);
    import ddcPkg::*;

    // LO peak is a power of two, so scaling back is a plain shift.
    localparam int loShift = $clog2(loAmplitude);

    logic signed [2*sampleWidth:0] prodI;
    logic signed [2*sampleWidth:0] prodQ;
    logic strobeDly;

    always_ff @(posedge clk) begin
        prodI <= sampleIn.i * loIn.i - sampleIn.q * loIn.q;
        prodQ <= sampleIn.i * loIn.q + sampleIn.q * loIn.i;
        mixOut.i <= saturate(prodI >>> loShift);
        mixOut.q <= saturate(prodQ >>> loShift);
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            strobeDly <= 1'b0;
            strobeOut <= 1'b0;
        end else begin
            strobeDly <= strobeIn;
            strobeOut <= strobeDly;
        end
    end

endmodule

`default_nettype wire

// ==== source/ddcLo.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcLo (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 syncIn,
    input  logic                 offsetEn,
    input  logic [31:0]          freqOffset,
    input  logic [31:0]          centerFreq,
    output ddcPkg::complexSample loOut,
    output logic                 loStrobe
);
    import ddcPkg::*;

    logic [31:0] loFreq;
    logic [31:0] phase;

    // first quarter of the cosine, scaled to the LO peak.
    function automatic int quarterMag(input int k);
        case (k)
            0: return loAmplitude;
            1: return 60547;
            2: return 46341;
            3: return 25080;
            default: return 0;
        endcase
    endfunction

    function automatic logic signed [sampleWidth-1:0] cosLookup(input logic [3:0] idx);
        int k;
        int mag;
        k = int'(idx);
        // fold into 0..8, then mirror the second quarter.
        if (k > 8) begin
            k = 16 - k;
        end
        if (k > 4) begin
            mag = -quarterMag(8 - k);
        end else begin
            mag = quarterMag(k);
        end
        return mag[sampleWidth-1:0];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            loFreq <= '0;
            phase <= '0;
            loStrobe <= 1'b0;
        end else begin
            if (offsetEn) begin
                loFreq <= freqOffset - centerFreq;
            end
            if (syncIn) begin
                phase <= phase + loFreq;
            end
            loStrobe <= syncIn;
        end
    end

    // sine is the cosine a quarter turn back.
    always_ff @(posedge clk) begin
        if (syncIn) begin
            loOut.i <= cosLookup(phase[31:28]);
            loOut.q <= cosLookup(phase[31:28] - 4'd4);
        end
    end

endmodule

`default_nettype wire

// ==== source/ddcRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddcRegs #(
    parameter int cicMaxRateLog2 = 4
) (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  logic [11:0]                           addr,
    input  logic [31:0]                           din,
    input  logic                                  wr0,
    input  logic                                  wr1,
    input  logic                                  wr2,
    input  logic                                  wr3,
    output logic [31:0]                           dout,
    output logic [31:0]                           centerFreq,
    output logic [$clog2(cicMaxRateLog2 + 1)-1:0] cicRateLog2
);
    import ddcPkg::*;

    localparam int rateWidth = $clog2(cicMaxRateLog2 + 1);

    logic [3:0] byteWr;
    logic centerSel;
    logic rateSel;
    logic [rateWidth-1:0] rateClamped;

    assign byteWr = {wr3, wr2, wr1, wr0};
    assign centerSel = (addr == centerFreqAddr);
    assign rateSel = (addr == cicRateAddr);

    // rate sits in the low byte, clamped to the largest supported exponent.
    assign rateClamped = (din[7:0] > cicMaxRateLog2) ? rateWidth'(cicMaxRateLog2)
                                                     : din[rateWidth-1:0];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            centerFreq <= '0;
            cicRateLog2 <= '0;
        end else begin
            for (int b = 0; b < 4; b++) begin
                if (centerSel && byteWr[b]) begin
                    centerFreq[8*b +: 8] <= din[8*b +: 8];
                end
            end
            if (rateSel && wr0) begin
                cicRateLog2 <= rateClamped;
            end
        end
    end

    // readback, zero when unmapped.
    always_comb begin
        dout = '0;
        if (centerSel) begin
            dout = centerFreq;
        end else if (rateSel) begin
            dout = 32'(cicRateLog2);
        end
    end

endmodule

`default_nettype wire

// ==== source/ddcPkg.sv ====
`default_nettype none

package ddcPkg;

    // width of each I and Q sample.
    localparam int sampleWidth = 18;
    localparam int sampleMax = (1 << (sampleWidth - 1)) - 1;
    localparam int sampleMin = -(1 << (sampleWidth - 1));

    // LO table peak, half of full scale.
    localparam int loAmplitude = 65536;

    // host register map.
    localparam logic [11:0] centerFreqAddr = 12'h000;
    localparam logic [11:0] cicRateAddr = 12'h004;

    typedef struct packed {
        logic signed [sampleWidth-1:0] i;
        logic signed [sampleWidth-1:0] q;
    } complexSample;

    typedef struct packed {
        logic [3:0] exponent;
        logic [15:0] mantissa;
    } gainSetting;

    // clip a wide signed value to the sample range.
    function automatic logic signed [sampleWidth-1:0] saturate(
        input logic signed [63:0] value
    );
        if (value > sampleMax) begin
            return sampleWidth'(sampleMax);
        end
        if (value < sampleMin) begin
            return sampleWidth'(sampleMin);
        end
        return value[sampleWidth-1:0];
    endfunction

endpackage

`default_nettype wire
